// File: project.f
verilog/audipus_pkg.sv
verilog/spi_register_file.sv
verilog/i2s_receiver.sv
verilog/gain_stage.sv
verilog/i2s_transmitter.sv
verilog/audio_path_top.sv
tb/audio_path_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the audio path testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module audio_path_tb \
    -Mdir obj_dir -o audio_path_sim -f project.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/audio_path_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0

// File: tb/audio_path_tb.sv
`timescale 1ns/1ps

module audio_path_tb
    import audipus_pkg::*;
();

    localparam int    SW           = 16;
    localparam int    FIFO_DEPTH   = 4;
    localparam int    BCLK_DIV     = 4;
    localparam int    CLK_PERIOD   = 20;
    localparam int    SPI_HALF     = 6;
    localparam int    FRAME_CLKS   = 2 * SW * 2 * BCLK_DIV;
    // frames sent by tests 2 to 5
    localparam int    TOTAL_FRAMES = 60;
    localparam longint WATCHDOG_NS = longint'(TOTAL_FRAMES) * FRAME_CLKS * 3 * CLK_PERIOD;
    localparam logic [31:0] SEED   = 32'he9d7;

    logic clk;
    logic rst;
    logic spi_cs_n;
    logic spi_clk;
    logic spi_mosi;
    logic spi_miso;
    logic pcm_bclk;
    logic pcm_lrclk;
    logic pcm_data;
    logic dac_bclk;
    logic dac_lrclk;
    logic dac_data;

    // testbench view of the register settings
    logic [7:0]  gain_l_cfg;
    logic [7:0]  gain_r_cfg;
    logic        mute_cfg;
    logic        out_enabled;
    logic        drop_mode;
    int          in_half;
    logic        prev_lsb;
    logic [31:0] exp_q[$];

    int errors;
    int tests_done;
    int frames_checked;
    int zero_skipped;
    int test_err_base;

    audio_path_top #(
        .SAMPLE_WIDTH (SW),
        .FIFO_DEPTH   (FIFO_DEPTH),
        .BCLK_DIV     (BCLK_DIV)
    ) i_audio_path_top (
        .clk       (clk),
        .rst       (rst),
        .spi_cs_n  (spi_cs_n),
        .spi_clk   (spi_clk),
        .spi_mosi  (spi_mosi),
        .spi_miso  (spi_miso),
        .pcm_bclk  (pcm_bclk),
        .pcm_lrclk (pcm_lrclk),
        .pcm_data  (pcm_data),
        .dac_bclk  (dac_bclk),
        .dac_lrclk (dac_lrclk),
        .dac_data  (dac_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model and checks
    ////////////////////////////////////////////////////////////////////////////

    // floor of sample * gain / 64 clamped to the signed sample range
    function automatic logic [SW-1:0] scaled(input logic [SW-1:0] s, input logic [7:0] g);
        longint p;
        longint hi;
        longint lo;
        hi = (longint'(1) <<< (SW - 1)) - 1;
        lo = -(longint'(1) <<< (SW - 1));
        p  = longint'($signed(s)) * longint'({1'b0, g});
        p  = p >>> 6;
        if (p > hi) p = hi;
        if (p < lo) p = lo;
        return p[SW-1:0];
    endfunction

    task automatic check_value(input string name, input logic [15:0] act, input logic [15:0] exp);
        assert (act === exp) else begin
            $display("FAIL %0t ns %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_frame(input logic [31:0] f);
        logic [31:0] exp;
        // silent underrun frame while nothing is due yet
        if (f == 32'h0 && (exp_q.size() == 0 || exp_q[0] != 32'h0)) begin
            zero_skipped++;
            return;
        end
        if (drop_mode) begin
            while (exp_q.size() > 0 && exp_q[0] != f) begin
                void'(exp_q.pop_front());
            end
        end
        assert (exp_q.size() > 0) else begin
            $display("at %0t ns a DAC frame %h arrived that matches no sent frame", $time, f);
            errors++;
            return;
        end
        exp = exp_q.pop_front();
        check_value("dac_left", f[31:16], exp[31:16]);
        check_value("dac_right", f[15:0], exp[15:0]);
        frames_checked++;
    endtask

    // rebuild frames from the dac pins
    // a frame ends on the falling lrclk
    initial begin : capture
        logic        prev_bclk;
        logic        prev_lr;
        logic [31:0] sh;
        prev_bclk = 1'b0;
        prev_lr   = 1'b0;
        sh        = '0;
        forever begin
            @(negedge clk);
            if (!out_enabled) begin
                prev_bclk = 1'b0;
                prev_lr   = 1'b0;
                sh        = '0;
            end else begin
                if (dac_bclk && !prev_bclk) begin
                    sh = {sh[30:0], dac_data};
                    if (!dac_lrclk && prev_lr) begin
                        check_frame(sh);
                    end
                    prev_lr = dac_lrclk;
                end
                prev_bclk = dac_bclk;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // spi and i2s drivers
    ////////////////////////////////////////////////////////////////////////////

    task automatic spi_xfer(input logic wr, input logic [6:0] addr, input logic [7:0] wdata,
                            output logic [7:0] rdata);
        logic [15:0] frame;
        frame = {wr, addr, wdata};
        rdata = '0;
        @(posedge clk);
        spi_cs_n <= 1'b0;
        repeat (SPI_HALF) @(posedge clk);
        for (int i = 15; i >= 0; i--) begin
            @(posedge clk);
            spi_mosi <= frame[i];
            spi_clk  <= 1'b0;
            repeat (SPI_HALF) @(posedge clk);
            // miso settled long before the rising edge
            if (i < 8) rdata[i] = spi_miso;
            spi_clk <= 1'b1;
            repeat (SPI_HALF - 1) @(posedge clk);
        end
        @(posedge clk);
        spi_clk <= 1'b0;
        repeat (SPI_HALF) @(posedge clk);
        spi_cs_n <= 1'b1;
        repeat (SPI_HALF) @(posedge clk);
    endtask

    task automatic spi_write(input logic [6:0] addr, input logic [7:0] data);
        logic [7:0] unused;
        spi_xfer(1'b1, addr, data, unused);
    endtask

    task automatic spi_read(input logic [6:0] addr, output logic [7:0] data);
        spi_xfer(1'b0, addr, 8'h00, data);
    endtask

    // one bit period with data and lrclk changing on the falling bclk
    task automatic i2s_bit(input logic lr, input logic d);
        @(posedge clk);
        pcm_bclk  <= 1'b0;
        pcm_lrclk <= lr;
        pcm_data  <= d;
        repeat (in_half - 1) @(posedge clk);
        @(posedge clk);
        pcm_bclk <= 1'b1;
        repeat (in_half - 1) @(posedge clk);
    endtask

    task automatic i2s_send_frame(input logic [SW-1:0] l, input logic [SW-1:0] r);
        i2s_bit(1'b0, prev_lsb);
        for (int k = SW - 1; k >= 1; k--) i2s_bit(1'b0, l[k]);
        i2s_bit(1'b1, l[0]);
        for (int k = SW - 1; k >= 1; k--) i2s_bit(1'b1, r[k]);
        prev_lsb = r[0];
        if (mute_cfg) exp_q.push_back(32'h0);
        else exp_q.push_back({scaled(l, gain_l_cfg), scaled(r, gain_r_cfg)});
    endtask

    // closing lrclk edge carries the last right lsb without a bclk pulse
    task automatic i2s_close();
        @(posedge clk);
        pcm_bclk  <= 1'b0;
        pcm_lrclk <= 1'b0;
        pcm_data  <= prev_lsb;
        repeat (4) @(posedge clk);
    endtask

    task automatic send_random(input int n);
        for (int i = 0; i < n; i++) i2s_send_frame(SW'($urandom), SW'($urandom));
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(posedge clk);
        repeat ((FIFO_DEPTH + 2) * FRAME_CLKS) @(posedge clk);
    endtask

    task automatic finish_test(input string name);
        tests_done++;
        $display("%s finished with %0d errors", name, errors - test_err_base);
        test_err_base = errors;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    initial begin : main
        logic [7:0]  rd;
        rst = 1'b1;
        spi_cs_n = 1'b1;
        spi_clk = 1'b0;
        spi_mosi = 1'b0;
        pcm_bclk = 1'b0;
        pcm_lrclk = 1'b0;
        pcm_data = 1'b0;
        gain_l_cfg = GAIN_UNITY;
        gain_r_cfg = GAIN_UNITY;
        mute_cfg = 1'b0;
        out_enabled = 1'b0;
        drop_mode = 1'b0;
        in_half = 4;
        prev_lsb = 1'b0;
        errors = 0;
        tests_done = 0;
        frames_checked = 0;
        zero_skipped = 0;
        test_err_base = 0;
        void'($urandom(SEED));
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);

        // register access
        spi_read(REG_GAIN_L, rd);
        check_value("gain_left", 16'(rd), 16'(GAIN_UNITY));
        spi_read(REG_GAIN_R, rd);
        check_value("gain_right", 16'(rd), 16'(GAIN_UNITY));
        spi_read(REG_CONTROL, rd);
        check_value("control", 16'(rd), 16'h0);
        spi_write(REG_CONTROL, 8'hA4);
        spi_write(REG_GAIN_L, 8'h5A);
        spi_write(REG_GAIN_R, 8'hC3);
        spi_read(REG_CONTROL, rd);
        check_value("control", 16'(rd), 16'h00A4);
        spi_read(REG_GAIN_L, rd);
        check_value("gain_left", 16'(rd), 16'h005A);
        spi_read(REG_GAIN_R, rd);
        check_value("gain_right", 16'(rd), 16'h00C3);
        spi_write(REG_CONTROL, 8'h00);
        spi_write(REG_GAIN_L, GAIN_UNITY);
        spi_write(REG_GAIN_R, GAIN_UNITY);
        finish_test("register access");

        // unity passthrough
        spi_write(REG_CONTROL, 8'h01);
        out_enabled = 1'b1;
        send_random(20);
        i2s_close();
        drain();
        finish_test("unity passthrough");

        // gain and saturation
        spi_write(REG_GAIN_L, 8'd128);
        spi_write(REG_GAIN_R, 8'd16);
        gain_l_cfg = 8'd128;
        gain_r_cfg = 8'd16;
        send_random(10);
        i2s_send_frame(16'h7FFF, 16'h8000);
        i2s_send_frame(16'h8000, 16'h7FFF);
        i2s_close();
        drain();
        finish_test("gain and saturation");

        // mute and then back to the gain rule
        spi_write(REG_CONTROL, 8'h03);
        mute_cfg = 1'b1;
        send_random(8);
        i2s_close();
        drain();
        spi_write(REG_CONTROL, 8'h01);
        mute_cfg = 1'b0;
        send_random(8);
        i2s_close();
        drain();
        finish_test("mute");

        // input twice as fast as the dac so frames get dropped
        drop_mode = 1'b1;
        in_half = 2;
        send_random(12);
        i2s_close();
        repeat ((FIFO_DEPTH + 2) * FRAME_CLKS) @(posedge clk);
        exp_q.delete();
        spi_read(REG_STATUS, rd);
        check_value("status_overflow", 16'(rd[STAT_OVERFLOW_BIT]), 16'h1);
        spi_write(REG_STATUS, 8'h01 << STAT_OVERFLOW_BIT);
        spi_read(REG_STATUS, rd);
        check_value("status_overflow", 16'(rd[STAT_OVERFLOW_BIT]), 16'h0);
        // no input now while the dac keeps running
        spi_write(REG_STATUS, 8'h01 << STAT_UNDERRUN_BIT);
        repeat (2 * FRAME_CLKS) @(posedge clk);
        spi_read(REG_STATUS, rd);
        check_value("status_underrun", 16'(rd[STAT_UNDERRUN_BIT]), 16'h1);
        finish_test("flow control");

        $display("tests %0d, frames checked %0d, zero frames skipped %0d, errors %0d",
                 tests_done, frames_checked, zero_skipped, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t ns before all tests finished", $time);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: verilog/audio_path_top.sv
`timescale 1ns/1ps

module audio_path_top #(
    parameter int SAMPLE_WIDTH = 16,
    parameter int FIFO_DEPTH   = 4,
    parameter int BCLK_DIV     = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic spi_cs_n,
    input  logic spi_clk,
    input  logic spi_mosi,
    output logic spi_miso,
    input  logic pcm_bclk,
    input  logic pcm_lrclk,
    input  logic pcm_data,
    output logic dac_bclk,
    output logic dac_lrclk,
    output logic dac_data
);

    ////////////////////////////////////////////////////////////////////////////
    // internal connections
    ////////////////////////////////////////////////////////////////////////////

    // control from the register file
    logic                    audio_enable;
    logic                    mute;
    logic [7:0]              gain_left;
    logic [7:0]              gain_right;

    // status events back to the register file
    logic                    drop_pulse;
    logic                    underrun_pulse;

    // receiver to gain stage
    logic                    frame_valid;
    logic [SAMPLE_WIDTH-1:0] left_sample;
    logic [SAMPLE_WIDTH-1:0] right_sample;

    // gain stage to transmitter, credit loop
    logic                    out_valid;
    logic [SAMPLE_WIDTH-1:0] out_left;
    logic [SAMPLE_WIDTH-1:0] out_right;
    logic                    credit_return;

    spi_register_file i_spi_register_file (
        .clk            (clk),
        .rst            (rst),
        .spi_cs_n       (spi_cs_n),
        .spi_clk        (spi_clk),
        .spi_mosi       (spi_mosi),
        .spi_miso       (spi_miso),
        .drop_pulse     (drop_pulse),
        .underrun_pulse (underrun_pulse),
        .audio_enable   (audio_enable),
        .mute           (mute),
        .gain_left      (gain_left),
        .gain_right     (gain_right)
    );

    // input side from the receiver chip
    i2s_receiver #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH)
    ) i_i2s_receiver (
        .clk          (clk),
        .rst          (rst),
        .pcm_bclk     (pcm_bclk),
        .pcm_lrclk    (pcm_lrclk),
        .pcm_data     (pcm_data),
        .frame_valid  (frame_valid),
        .left_sample  (left_sample),
        .right_sample (right_sample)
    );

    gain_stage #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) i_gain_stage (
        .clk           (clk),
        .rst           (rst),
        .frame_valid   (frame_valid),
        .left_sample   (left_sample),
        .right_sample  (right_sample),
        .gain_left     (gain_left),
        .gain_right    (gain_right),
        .mute          (mute),
        .audio_enable  (audio_enable),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_left      (out_left),
        .out_right     (out_right),
        .drop_pulse    (drop_pulse)
    );

    // dac side
    i2s_transmitter #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH),
        .FIFO_DEPTH   (FIFO_DEPTH),
        .BCLK_DIV     (BCLK_DIV)
    ) i_i2s_transmitter (
        .clk            (clk),
        .rst            (rst),
        .audio_enable   (audio_enable),
        .in_valid       (out_valid),
        .in_left        (out_left),
        .in_right       (out_right),
        .credit_return  (credit_return),
        .underrun_pulse (underrun_pulse),
        .dac_bclk       (dac_bclk),
        .dac_lrclk      (dac_lrclk),
        .dac_data       (dac_data)
    );

endmodule

// File: verilog/i2s_transmitter.sv
`timescale 1ns/1ps

module i2s_transmitter
    import audipus_pkg::*;
#(
    parameter int SAMPLE_WIDTH = 16,
    parameter int FIFO_DEPTH   = 4,
    parameter int BCLK_DIV     = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    audio_enable,
    input  logic                    in_valid,
    input  logic [SAMPLE_WIDTH-1:0] in_left,
    input  logic [SAMPLE_WIDTH-1:0] in_right,
    output logic                    credit_return,
    output logic                    underrun_pulse,
    output logic                    dac_bclk,
    output logic                    dac_lrclk,
    output logic                    dac_data
);

    localparam int FRAME_W = 2 * SAMPLE_WIDTH;
    localparam int PTR_W   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int DIV_W   = $clog2(BCLK_DIV + 1);
    localparam int SLOT_W  = $clog2(FRAME_W);

    // frame buffer, left word in the upper half
    logic [FRAME_W-1:0]      mem [FIFO_DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [CREDIT_WIDTH-1:0] fill;
    logic                    push;
    logic                    pop;

    // bit clock and slot tracking
    logic [DIV_W-1:0]        div_cnt;
    logic                    div_tick;
    logic                    bclk_fall;
    logic                    frame_start;
    logic [SLOT_W-1:0]       slot;
    logic [FRAME_W-1:0]      shift_reg;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + PTR_W'(1);
    endfunction

    assign div_tick    = (div_cnt == DIV_W'(BCLK_DIV - 1));
    assign bclk_fall   = div_tick & dac_bclk;
    assign frame_start = bclk_fall & (slot == '0);
    assign pop         = frame_start & (fill != '0);
    assign push        = in_valid & audio_enable & (fill < CREDIT_WIDTH'(FIFO_DEPTH));

    ////////////////////////////////////////////////////////////////////////////
    // circular buffer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {in_left, in_right};
        end
    end

    // disabled output flushes the buffer
    always_ff @(posedge clk) begin
        if (rst || !audio_enable) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            fill <= fill + CREDIT_WIDTH'(push) - CREDIT_WIDTH'(pop);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // serializer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || !audio_enable) begin
            div_cnt        <= '0;
            dac_bclk       <= 1'b0;
            dac_lrclk      <= 1'b0;
            dac_data       <= 1'b0;
            slot           <= '0;
            shift_reg      <= '0;
            credit_return  <= 1'b0;
            underrun_pulse <= 1'b0;
        end else begin
            credit_return  <= pop;
            underrun_pulse <= frame_start & ~pop;
            if (div_tick) begin
                div_cnt  <= '0;
                dac_bclk <= ~dac_bclk;
            end else begin
                div_cnt <= div_cnt + DIV_W'(1);
            end
            // data and lrclk move on falling bclk
            if (bclk_fall) begin
                dac_lrclk <= (slot >= SLOT_W'(SAMPLE_WIDTH));
                // slot 0 still carries the previous right lsb
                dac_data  <= shift_reg[FRAME_W-1];
                slot      <= (slot == SLOT_W'(FRAME_W - 1)) ? '0 : slot + SLOT_W'(1);
                if (frame_start) begin
                    // empty buffer sends a silent frame
                    shift_reg <= pop ? mem[rd_ptr] : '0;
                end else begin
                    shift_reg <= {shift_reg[FRAME_W-2:0], 1'b0};
                end
            end
        end
    end

endmodule

// File: verilog/gain_stage.sv
`timescale 1ns/1ps

module gain_stage
    import audipus_pkg::*;
#(
    parameter int SAMPLE_WIDTH = 16,
    parameter int FIFO_DEPTH   = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    frame_valid,
    input  logic [SAMPLE_WIDTH-1:0] left_sample,
    input  logic [SAMPLE_WIDTH-1:0] right_sample,
    input  logic [7:0]              gain_left,
    input  logic [7:0]              gain_right,
    input  logic                    mute,
    input  logic                    audio_enable,
    input  logic                    credit_return,
    output logic                    out_valid,
    output logic [SAMPLE_WIDTH-1:0] out_left,
    output logic [SAMPLE_WIDTH-1:0] out_right,
    output logic                    drop_pulse
);

    // signed sample times zero-extended 9-bit gain
    localparam int PROD_W = SAMPLE_WIDTH + 9;

    logic [CREDIT_WIDTH-1:0]  credits;
    logic                     admit;
    logic                     s1_valid;
    logic signed [PROD_W-1:0] s1_left;
    logic signed [PROD_W-1:0] s1_right;

    // drop the fraction bits, then clamp to the sample range
    function automatic logic [SAMPLE_WIDTH-1:0] saturate(input logic signed [PROD_W-1:0] p);
        logic signed [PROD_W-1:0]      s;
        logic [PROD_W-SAMPLE_WIDTH:0]  top;
        s   = p >>> GAIN_SHIFT;
        top = s[PROD_W-1:SAMPLE_WIDTH-1];
        // all sign copies equal, value fits
        if (&top || ~|top) begin
            return s[SAMPLE_WIDTH-1:0];
        end
        if (s[PROD_W-1]) begin
            return {1'b1, {(SAMPLE_WIDTH-1){1'b0}}};
        end
        return {1'b0, {(SAMPLE_WIDTH-1){1'b1}}};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // credits
    ////////////////////////////////////////////////////////////////////////////

    // credit is reserved on entry, so frames in flight count as spent
    assign admit = frame_valid & audio_enable & (credits != '0);

    always_ff @(posedge clk) begin
        if (rst || !audio_enable) begin
            credits <= CREDIT_WIDTH'(FIFO_DEPTH);
        end else begin
            credits <= credits - CREDIT_WIDTH'(admit) + CREDIT_WIDTH'(credit_return);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            drop_pulse <= 1'b0;
        end else begin
            drop_pulse <= frame_valid & audio_enable & (credits == '0);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // two-stage datapath
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || !audio_enable) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= admit;
            out_valid <= s1_valid;
        end
    end

    // stage 1, multiply
    always_ff @(posedge clk) begin
        if (admit) begin
            s1_left  <= $signed(left_sample) * $signed({1'b0, gain_left});
            s1_right <= $signed(right_sample) * $signed({1'b0, gain_right});
        end
    end

    // stage 2, shift and clamp, mute forces silence
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            out_left  <= mute ? '0 : saturate(s1_left);
            out_right <= mute ? '0 : saturate(s1_right);
        end
    end

endmodule

// File: verilog/i2s_receiver.sv
`timescale 1ns/1ps

module i2s_receiver #(
    parameter int SAMPLE_WIDTH = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pcm_bclk,
    input  logic                    pcm_lrclk,
    input  logic                    pcm_data,
    output logic                    frame_valid,
    output logic [SAMPLE_WIDTH-1:0] left_sample,
    output logic [SAMPLE_WIDTH-1:0] right_sample
);

    localparam int CNT_W = $clog2(SAMPLE_WIDTH + 1);

    // two sync flops plus history for bclk and lrclk
    logic [2:0]              bclk_sync;
    logic [2:0]              lrclk_sync;
    logic [1:0]              data_sync;
    logic                    bclk_rise;
    logic                    lr_edge;
    logic                    data_bit;

    // 0 marks the delay slot, 1..SAMPLE_WIDTH-1 shift msb down to bit 1
    logic [CNT_W-1:0]        bit_cnt;
    logic [SAMPLE_WIDTH-2:0] shift_reg;
    logic [SAMPLE_WIDTH-1:0] word;
    logic [SAMPLE_WIDTH-1:0] left_hold;
    logic                    have_left;

    always_ff @(posedge clk) begin
        if (rst) begin
            bclk_sync  <= 3'b000;
            lrclk_sync <= 3'b000;
            data_sync  <= 2'b00;
        end else begin
            bclk_sync  <= {bclk_sync[1:0], pcm_bclk};
            lrclk_sync <= {lrclk_sync[1:0], pcm_lrclk};
            data_sync  <= {data_sync[0], pcm_data};
        end
    end

    assign bclk_rise = bclk_sync[1] & ~bclk_sync[2];
    assign lr_edge   = lrclk_sync[1] ^ lrclk_sync[2];
    assign data_bit  = data_sync[1];

    // lsb rides the line as lrclk flips, so the word closes on the edge
    assign word = {shift_reg, data_bit};

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt     <= '0;
            have_left   <= 1'b0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            if (lr_edge) begin
                bit_cnt <= '0;
                if (!lrclk_sync[2]) begin
                    // low to high, left channel just ended
                    have_left <= 1'b1;
                end else if (have_left) begin
                    have_left   <= 1'b0;
                    frame_valid <= 1'b1;
                end
            end else if (bclk_rise) begin
                if (bit_cnt == '0) begin
                    bit_cnt <= CNT_W'(1);
                end else if (bit_cnt < CNT_W'(SAMPLE_WIDTH)) begin
                    bit_cnt <= bit_cnt + CNT_W'(1);
                end
            end
        end
    end

    // sample payload
    always_ff @(posedge clk) begin
        if (!lr_edge && bclk_rise && bit_cnt != '0 && bit_cnt < CNT_W'(SAMPLE_WIDTH)) begin
            shift_reg <= {shift_reg[SAMPLE_WIDTH-3:0], data_bit};
        end
        if (lr_edge && !lrclk_sync[2]) begin
            left_hold <= word;
        end
        if (lr_edge && lrclk_sync[2] && have_left) begin
            left_sample  <= left_hold;
            right_sample <= word;
        end
    end

endmodule

// File: verilog/spi_register_file.sv
`timescale 1ns/1ps

module spi_register_file
    import audipus_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       spi_cs_n,
    input  logic       spi_clk,
    input  logic       spi_mosi,
    output logic       spi_miso,
    input  logic       drop_pulse,
    input  logic       underrun_pulse,
    output logic       audio_enable,
    output logic       mute,
    output logic [7:0] gain_left,
    output logic [7:0] gain_right
);

    // pin synchronizers, sclk keeps one extra flop for edge detect
    logic [1:0] cs_sync;
    logic [2:0] sclk_sync;
    logic [1:0] mosi_sync;
    logic       cs_active;
    logic       sclk_rise;
    logic       sclk_fall;
    logic       mosi_bit;

    // frame state
    logic [3:0] bit_cnt;
    logic [6:0] shift_in;
    logic       wr_flag;
    logic [6:0] addr;
    logic [6:0] hdr_addr;
    logic [7:0] wr_data;
    logic [7:0] rd_data;
    logic [7:0] miso_shift;
    logic       wr_commit;
    logic [1:0] stat_clr;

    // register storage
    logic [7:0] ctrl_reg;
    logic [1:0] stat_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            cs_sync   <= 2'b11;
            sclk_sync <= 3'b000;
            mosi_sync <= 2'b00;
        end else begin
            cs_sync   <= {cs_sync[0], spi_cs_n};
            sclk_sync <= {sclk_sync[1:0], spi_clk};
            mosi_sync <= {mosi_sync[0], spi_mosi};
        end
    end

    assign cs_active = ~cs_sync[1];
    assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
    assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
    assign mosi_bit  = mosi_sync[1];

    // header byte completes on the 8th rising edge, data byte on the 16th
    assign hdr_addr  = {shift_in[5:0], mosi_bit};
    assign wr_data   = {shift_in, mosi_bit};
    assign wr_commit = cs_active & sclk_rise & (bit_cnt == 4'd15) & wr_flag;
    assign stat_clr  = (wr_commit && addr == REG_STATUS) ? wr_data[1:0] : 2'b00;

    // read mux, indexed by the address still in the shifter
    always_comb begin
        case (hdr_addr)
            REG_CONTROL: rd_data = ctrl_reg;
            REG_GAIN_L:  rd_data = gain_left;
            REG_GAIN_R:  rd_data = gain_right;
            REG_STATUS:  rd_data = {6'b000000, stat_reg};
            default:     rd_data = 8'h00;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // mode 0 shifter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || !cs_active) begin
            bit_cnt    <= 4'd0;
            shift_in   <= 7'd0;
            wr_flag    <= 1'b0;
            addr       <= 7'd0;
            miso_shift <= 8'h00;
        end else if (sclk_rise) begin
            bit_cnt  <= bit_cnt + 4'd1;
            shift_in <= {shift_in[5:0], mosi_bit};
            if (bit_cnt == 4'd7) begin
                // rw flag is the first bit of the frame
                wr_flag    <= shift_in[6];
                addr       <= hdr_addr;
                miso_shift <= rd_data;
            end
        end else if (sclk_fall && bit_cnt > 4'd8) begin
            // next read bit, msb already sits on miso
            miso_shift <= {miso_shift[6:0], 1'b0};
        end
    end

    assign spi_miso = cs_active & miso_shift[7];

    ////////////////////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_reg   <= 8'h00;
            gain_left  <= GAIN_UNITY;
            gain_right <= GAIN_UNITY;
            stat_reg   <= 2'b00;
        end else begin
            if (wr_commit) begin
                case (addr)
                    REG_CONTROL: ctrl_reg   <= wr_data;
                    REG_GAIN_L:  gain_left  <= wr_data;
                    REG_GAIN_R:  gain_right <= wr_data;
                    default:     ;
                endcase
            end
            // a new event wins over a clear in the same cycle
            stat_reg[STAT_OVERFLOW_BIT] <= (stat_reg[STAT_OVERFLOW_BIT]
                                            & ~stat_clr[STAT_OVERFLOW_BIT]) | drop_pulse;
            stat_reg[STAT_UNDERRUN_BIT] <= (stat_reg[STAT_UNDERRUN_BIT]
                                            & ~stat_clr[STAT_UNDERRUN_BIT]) | underrun_pulse;
        end
    end

    assign audio_enable = ctrl_reg[CTRL_ENABLE_BIT];
    assign mute         = ctrl_reg[CTRL_MUTE_BIT];

endmodule

// File: verilog/audipus_pkg.sv
package audipus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // spi register map
    ////////////////////////////////////////////////////////////////////////////

    // 7-bit addresses as sent in the spi header
    localparam logic [6:0] REG_CONTROL = 7'd0;
    localparam logic [6:0] REG_GAIN_L  = 7'd1;
    localparam logic [6:0] REG_GAIN_R  = 7'd2;
    localparam logic [6:0] REG_STATUS  = 7'd3;

    // control register bits
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_MUTE_BIT   = 1;

    // sticky status bits, cleared by writing ones
    localparam int STAT_OVERFLOW_BIT = 0;
    localparam int STAT_UNDERRUN_BIT = 1;

    ////////////////////////////////////////////////////////////////////////////
    // gain format and flow control
    ////////////////////////////////////////////////////////////////////////////

    // unsigned gain with 6 fraction bits, 64 is x1.0
    localparam logic [7:0] GAIN_UNITY = 8'd64;
    localparam int         GAIN_SHIFT = 6;

    // wide enough to count a full frame buffer
    localparam int CREDIT_WIDTH = 3;

endpackage
